/* storeGather.f */
hdl/coreStorePkg.sv
hdl/memRowPkg.sv
hdl/storeIntake.sv
hdl/gatherBank.sv
hdl/rowFlush.sv
hdl/storeGather.sv
bench/storeGatherTb.sv

/* Bender.yml */
package:
  name: storeGather

sources:
  - hdl/coreStorePkg.sv
  - hdl/memRowPkg.sv
  - hdl/storeIntake.sv
  - hdl/gatherBank.sv
  - hdl/rowFlush.sv
  - hdl/storeGather.sv
  - target: test
    files:
      - bench/storeGatherTb.sv

/* bench/storeGatherTb.sv */
module storeGatherTb;
    timeunit 1ns;
    timeprecision 100ps;

    import coreStorePkg::*;
    import memRowPkg::*;

    localparam int StoreDepth = 2;
    localparam int MemCredits = 2;
    // stores issued before the drain phase starts
    localparam int MainStores = 200;
    // memory keeps its credits back inside this window
    localparam int HoldStart = 40;
    localparam int HoldEnd = 240;
    localparam int WatchdogCycles = MainStores * 20;

    logic clk;
    logic reset;
    logic [NumCores-1:0] storeValid;
    coreStore [NumCores-1:0] stores;
    logic [NumCores-1:0] storeCredit;
    logic memValid;
    memRow memData;
    logic memCredit;

    logic [31:0] lfsrState = 32'h18da_e3ba;
    int errorCount = 0;
    int rowsChecked = 0;
    int storesIssued = 0;
    int cycleCount = 0;
    int memCreditsLeft = MemCredits;
    bit firstStoreSeen = 1'b0;
    int storeCredits [NumCores];
    int storesSent [NumCores];
    int creditsBack [NumCores];
    // due cycles of memory credit returns
    int returnQueue [$];
    // reference model holding at most one unseen store per core and row
    bit pendValid [NumCores][NumRows];
    bit pendFlush [NumCores][NumRows];
    logic [WordWidth-1:0] pendData [NumCores][NumRows];

    storeGather #(
        .StoreDepth (StoreDepth),
        .MemCredits (MemCredits)
    ) storeGather_i (
        .clk         (clk),
        .reset       (reset),
        .storeValid  (storeValid),
        .stores      (stores),
        .storeCredit (storeCredit),
        .memValid    (memValid),
        .memData     (memData),
        .memCredit   (memCredit)
    );

    always #4 clk = ~clk;

    // fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++)
        begin
            lfsrState = {lfsrState[30:0],
                         lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic int outstandingCount();
        int n;
        n = 0;
        for (int c = 0; c < NumCores; c++)
            for (int r = 0; r < NumRows; r++)
                n += pendValid[c][r];
        return n;
    endfunction

    // row still holds a plain store that nothing will flush by itself
    function automatic bit rowHasPlain(input int r);
        bit found;
        found = 1'b0;
        for (int c = 0; c < NumCores; c++)
            found |= pendValid[c][r] && !pendFlush[c][r];
        return found;
    endfunction

    // match one memRow against the stores the bench has issued to that row
    function automatic void checkRow();
        logic [RowAddrWidth-1:0] r;
        logic [WordWidth-1:0] got;
        bit sawFlush;
        r = memData.rowAddr;
        sawFlush = 1'b0;
        rowsChecked++;
        assert (memData.wordMask != '0)
        else
        begin
            errorCount++;
            $display("memRow for row %0d at %0t carries no words", r, $time);
        end
        for (int k = 0; k < RowWords; k++)
        begin
            // word 0 in the top bits
            got = memData.data[(RowWords - 1 - k) * WordWidth +: WordWidth];
            if (memData.wordMask[k])
            begin
                assert (pendValid[k][r])
                else
                begin
                    errorCount++;
                    $display("memRow row %0d word %0d at %0t has no store from core %0d",
                             r, k, $time, k);
                end
                if (pendValid[k][r])
                begin
                    assert (got == pendData[k][r])
                    else
                    begin
                        errorCount++;
                        $display("ERROR %0t memData.data row %0d word %0d: got %h expected %h",
                                 $time, r, k, got, pendData[k][r]);
                    end
                    sawFlush |= pendFlush[k][r];
                    pendValid[k][r] = 1'b0;
                end
            end
        end
        // a partial mask needs a flush store among its words
        assert (memData.wordMask == '1 || sawFlush)
        else
        begin
            errorCount++;
            $display("ERROR %0t memData.wordMask row %0d: got %b expected %b",
                     $time, r, memData.wordMask, {RowWords{1'b1}});
        end
    endfunction

    // nothing comes back before the first store goes in
    assert property (@(posedge clk) disable iff (reset)
        firstStoreSeen || (storeCredit == '0 && !memValid))
    else
    begin
        errorCount++;
        $display("ERROR %0t storeCredit/memValid: got %b/%b expected 0/0",
                 $time, $sampled(storeCredit), $sampled(memValid));
    end

    assert property (@(posedge clk) disable iff (reset)
        !(memValid && memCreditsLeft == 0))
    else
    begin
        errorCount++;
        $display("memValid issued at %0t without a memory credit", $time);
    end

    for (genvar c = 0; c < NumCores; c++)
    begin : creditChecks
        assert property (@(posedge clk) disable iff (reset)
            creditsBack[c] <= storesSent[c])
        else
        begin
            errorCount++;
            $display("core %0d got more credits back than stores it sent at %0t", c, $time);
        end
    end

    // stimulus, bookkeeping and memory responder all run on the rising edge
    always @(posedge clk)
    begin : benchStep
        logic [NumCores-1:0] nextValid;
        coreStore [NumCores-1:0] nextStores;
        logic [RowAddrWidth-1:0] row;
        bit issue;
        bit isFlush;
        if (reset)
        begin
            storeValid <= '0;
            memCredit  <= 1'b0;
            memCreditsLeft = MemCredits;
            for (int c = 0; c < NumCores; c++)
            begin
                storeCredits[c] = StoreDepth;
                storesSent[c] = 0;
                creditsBack[c] = 0;
                for (int r = 0; r < NumRows; r++)
                    pendValid[c][r] = 1'b0;
            end
        end
        else
        begin
            cycleCount++;
            for (int c = 0; c < NumCores; c++)
            begin
                storeCredits[c] += storeCredit[c];
                creditsBack[c] += storeCredit[c];
            end
            if (storeValid != '0)
                firstStoreSeen = 1'b1;
            memCreditsLeft += memCredit;
            if (memValid)
            begin
                memCreditsLeft--;
                checkRow();
                returnQueue.push_back(cycleCount + 2 + int'(randBits(3)));
            end
            // one credit back per cycle at most and none inside the hold window
            memCredit <= 1'b0;
            if (!(cycleCount >= HoldStart && cycleCount < HoldEnd) &&
                returnQueue.size() != 0 && returnQueue[0] <= cycleCount)
            begin
                memCredit <= 1'b1;
                void'(returnQueue.pop_front());
            end
            nextValid = '0;
            nextStores = stores;
            for (int c = 0; c < NumCores; c++)
            begin
                issue = 1'b0;
                isFlush = 1'b1;
                row = '0;
                if (storeCredits[c] > 0 && storesIssued < MainStores)
                begin
                    issue = (randBits(1) != 0);
                    row = RowAddrWidth'(randBits(2));
                    isFlush = (randBits(3) == 0);
                    issue = issue && !pendValid[c][row];
                end
                else if (storeCredits[c] > 0)
                begin
                    // drain phase flushes rows still holding plain stores
                    for (int r = NumRows - 1; r >= 0; r--)
                    begin
                        if (!pendValid[c][r] && rowHasPlain(r))
                        begin
                            row = RowAddrWidth'(r);
                            issue = 1'b1;
                        end
                    end
                end
                if (issue)
                begin
                    nextValid[c] = 1'b1;
                    nextStores[c].op = isFlush ? opStoreFlush : opStore;
                    // core c owns word c of every row
                    nextStores[c].wordAddr = {row, RowAddrWidth'(c)};
                    nextStores[c].data = WordWidth'(randBits(WordWidth));
                    pendValid[c][row] = 1'b1;
                    pendFlush[c][row] = isFlush;
                    pendData[c][row] = nextStores[c].data;
                    storeCredits[c]--;
                    storesSent[c]++;
                    storesIssued++;
                end
            end
            storeValid <= nextValid;
            stores     <= nextStores;
        end
    end

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        storeValid = '0;
        stores = '0;
        memCredit = 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        // run until every store has shown up in memory and credits are home
        while (storesIssued < MainStores || cycleCount < HoldEnd ||
               outstandingCount() != 0 || returnQueue.size() != 0)
            @(posedge clk);
        repeat (8) @(posedge clk);
        for (int c = 0; c < NumCores; c++)
        begin
            assert (storeCredits[c] == StoreDepth)
            else
            begin
                errorCount++;
                $display("ERROR %0t storeCredits[%0d]: got %0d expected %0d",
                         $time, c, storeCredits[c], StoreDepth);
            end
        end
        $display("errors %0d, rows %0d, stores %0d", errorCount, rowsChecked, storesIssued);
        if (errorCount == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    // watchdog
    initial
    begin
        repeat (WatchdogCycles) @(posedge clk);
        errorCount++;
        $display("watchdog expired after %0d cycles, %0d stores never reached memory",
                 WatchdogCycles, outstandingCount());
        $display("errors %0d, rows %0d, stores %0d", errorCount, rowsChecked, storesIssued);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* hdl/storeGather.sv */
module storeGather #(
    parameter int StoreDepth = 2,
    parameter int MemCredits = 2
) (
    input  logic                                               clk,
    input  logic                                               reset,
    input  logic [coreStorePkg::NumCores-1:0]                  storeValid,
    input  coreStorePkg::coreStore [coreStorePkg::NumCores-1:0] stores,
    output logic [coreStorePkg::NumCores-1:0]                  storeCredit,
    output logic                                               memValid,
    output memRowPkg::memRow                                   memData,
    input  logic                                               memCredit
);
    import coreStorePkg::*;
    import memRowPkg::*;

    // intake to bank
    logic                    wrValid;
    bankWrite                wr;
    logic [NumRows-1:0]      rowBusy;

    // bank to flush
    rowRequest               req;
    logic                    releaseValid;
    logic [RowAddrWidth-1:0] releaseRow;

    // stage 1, per-core FIFOs and arbitration
    storeIntake #(
        .StoreDepth (StoreDepth)
    ) storeIntake_i (
        .clk         (clk),
        .reset       (reset),
        .storeValid  (storeValid),
        .stores      (stores),
        .storeCredit (storeCredit),
        .rowBusy     (rowBusy),
        .wrValid     (wrValid),
        .wr          (wr)
    );

    // stage 2, word gathering
    gatherBank gatherBank_i (
        .clk          (clk),
        .reset        (reset),
        .wrValid      (wrValid),
        .wr           (wr),
        .rowBusy      (rowBusy),
        .req          (req),
        .releaseValid (releaseValid),
        .releaseRow   (releaseRow)
    );

    // stage 3, row writes to memory
    rowFlush #(
        .MemCredits (MemCredits)
    ) rowFlush_i (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .releaseValid (releaseValid),
        .releaseRow   (releaseRow),
        .memValid     (memValid),
        .memData      (memData),
        .memCredit    (memCredit)
    );

endmodule

/* hdl/rowFlush.sv */
module rowFlush #(
    parameter int MemCredits = 2
) (
    input  logic                               clk,
    input  logic                               reset,
    input  memRowPkg::rowRequest               req,
    output logic                               releaseValid,
    output logic [memRowPkg::RowAddrWidth-1:0] releaseRow,
    output logic                               memValid,
    output memRowPkg::memRow                   memData,
    input  logic                               memCredit
);
    import memRowPkg::*;

    localparam int CreditWidth = $clog2(MemCredits + 1);

    // row writes memory can still accept
    logic [CreditWidth-1:0]  credits;
    logic                    haveCredit;
    logic [RowAddrWidth-1:0] selRow;

    assign haveCredit = (credits != '0);

    // lowest-numbered pending row wins
    always_comb
    begin
        selRow = '0;
        for (int r = NumRows - 1; r >= 0; r--)
        begin
            if (req.pending[r])
                selRow = RowAddrWidth'(r);
        end
    end

    // issue in the cycle after the row turns pending
    assign memValid = haveCredit && (req.pending != '0);

    // bank drops the row on the edge that ends this cycle
    assign releaseValid = memValid;
    assign releaseRow   = selRow;

    // pack the row write
    always_comb
    begin
        memData.rowAddr = selRow;
        memData.data    = req.rowData[selRow];
        // a complete row always goes out with the full mask
        if (req.partial[selRow])
            memData.wordMask = req.wordMask[selRow];
        else
            memData.wordMask = '1;
    end

    // spend on memValid, refill on memCredit, both at once cancel
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            credits <= CreditWidth'(MemCredits);
        end
        else
        begin
            credits <= credits + CreditWidth'(memCredit) - CreditWidth'(memValid);
        end
    end

endmodule

/* hdl/gatherBank.sv */
module gatherBank (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              wrValid,
    input  coreStorePkg::bankWrite            wr,
    output logic [memRowPkg::NumRows-1:0]     rowBusy,
    output memRowPkg::rowRequest              req,
    input  logic                              releaseValid,
    input  logic [memRowPkg::RowAddrWidth-1:0] releaseRow
);
    import coreStorePkg::*;
    import memRowPkg::*;

    // low address bits pick the word within a row
    localparam int ColWidth = WordAddrWidth - RowAddrWidth;

    // the sixteen word registers, [row][word]
    logic [WordWidth-1:0]             words [NumRows][RowWords];
    logic [NumRows-1:0][RowWords-1:0] valid;
    logic [NumRows-1:0]               pending;
    logic [NumRows-1:0]               partial;

    logic [RowAddrWidth-1:0]          wrRow;
    logic [ColWidth-1:0]              wrCol;
    logic [RowWords-1:0]              newValid;
    logic                             rowDone;

    assign wrRow = wr.wordAddr[WordAddrWidth-1 -: RowAddrWidth];
    assign wrCol = wr.wordAddr[ColWidth-1:0];

    // valid mask of the target row once this write lands
    always_comb
    begin
        newValid        = valid[wrRow];
        newValid[wrCol] = 1'b1;
    end

    // all four words present, the gather condition
    assign rowDone = &newValid;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid   <= '0;
            pending <= '0;
            partial <= '0;
        end
        else
        begin
            // row has gone to memory, start gathering it afresh
            if (releaseValid)
            begin
                valid[releaseRow]   <= '0;
                pending[releaseRow] <= 1'b0;
                partial[releaseRow] <= 1'b0;
            end
            // intake never targets a pending row, so this cannot hit the released row
            if (wrValid)
            begin
                valid[wrRow] <= newValid;
                if (rowDone || wr.flush)
                begin
                    pending[wrRow] <= 1'b1;
                    // flush of an incomplete row goes out with a partial mask
                    partial[wrRow] <= !rowDone;
                end
            end
        end
    end

    // word storage
    always_ff @(posedge clk)
    begin
        if (wrValid)
            words[wrRow][wrCol] <= wr.data;
    end

    // pending rows are frozen until released
    assign rowBusy = pending;

    // present the bank to the flush stage
    always_comb
    begin
        req.pending  = pending;
        req.partial  = partial;
        req.wordMask = valid;
        for (int r = 0; r < NumRows; r++)
        begin
            for (int k = 0; k < RowWords; k++)
            begin
                // word 0 lands in the top bits
                req.rowData[r][(RowWords - 1 - k) * WordWidth +: WordWidth] = words[r][k];
            end
        end
    end

endmodule

/* hdl/storeIntake.sv */
module storeIntake #(
    parameter int StoreDepth = 2
) (
    input  logic                                               clk,
    input  logic                                               reset,
    input  logic [coreStorePkg::NumCores-1:0]                  storeValid,
    input  coreStorePkg::coreStore [coreStorePkg::NumCores-1:0] stores,
    output logic [coreStorePkg::NumCores-1:0]                  storeCredit,
    input  logic [memRowPkg::NumRows-1:0]                      rowBusy,
    output logic                                               wrValid,
    output coreStorePkg::bankWrite                             wr
);
    import coreStorePkg::*;
    import memRowPkg::*;

    localparam int PtrWidth    = (StoreDepth > 1) ? $clog2(StoreDepth) : 1;
    localparam int CountWidth  = $clog2(StoreDepth + 1);
    localparam int CoreIdWidth = $clog2(NumCores);

    // per-core FIFO storage, sized to the credits a core holds
    coreStore               fifoMem [NumCores][StoreDepth];
    logic [PtrWidth-1:0]    rdPtr [NumCores];
    logic [PtrWidth-1:0]    wrPtr [NumCores];
    logic [CountWidth-1:0]  count [NumCores];
    coreStore               head [NumCores];

    logic [CoreIdWidth-1:0] lastGrant;
    logic [NumRows-1:0]     blocked;
    logic [NumCores-1:0]    eligible;
    logic [NumCores-1:0]    grant;
    logic [CoreIdWidth-1:0] grantId;

    function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
        // wrap explicitly, depth need not be a power of two
        return (ptr == PtrWidth'(StoreDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // rows the bank is flushing, plus the row of the write still in flight
    // since that write may complete its row on the next edge
    always_comb
    begin
        blocked = rowBusy;
        if (wrValid)
        begin
            blocked[wr.wordAddr[WordAddrWidth-1 -: RowAddrWidth]] = 1'b1;
        end
    end

    // a core competes only if its head store targets a free row
    always_comb
    begin
        for (int i = 0; i < NumCores; i++)
        begin
            head[i]     = fifoMem[i][rdPtr[i]];
            eligible[i] = (count[i] != '0) &&
                          !blocked[head[i].wordAddr[WordAddrWidth-1 -: RowAddrWidth]];
        end
    end

    // round-robin, search starts one past the last winner
    always_comb
    begin
        logic [CoreIdWidth-1:0] cand;
        grant   = '0;
        grantId = lastGrant;
        for (int k = 1; k <= NumCores; k++)
        begin
            cand = CoreIdWidth'((int'(lastGrant) + k) % NumCores);
            if ((grant == '0) && eligible[cand])
            begin
                grant[cand] = 1'b1;
                grantId     = cand;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < NumCores; i++)
            begin
                rdPtr[i] <= '0;
                wrPtr[i] <= '0;
                count[i] <= '0;
            end
            lastGrant   <= '0;
            storeCredit <= '0;
            wrValid     <= 1'b0;
        end
        else
        begin
            // credits keep the push side from ever overflowing
            for (int i = 0; i < NumCores; i++)
            begin
                if (storeValid[i])
                    wrPtr[i] <= nextPtr(wrPtr[i]);
                if (grant[i])
                    rdPtr[i] <= nextPtr(rdPtr[i]);
                count[i] <= count[i] + CountWidth'(storeValid[i]) - CountWidth'(grant[i]);
            end
            if (grant != '0)
                lastGrant <= grantId;
            // credit goes back one cycle after the grant
            storeCredit <= grant;
            wrValid     <= |grant;
        end
    end

    // payload path
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < NumCores; i++)
        begin
            if (storeValid[i])
                fifoMem[i][wrPtr[i]] <= stores[i];
        end
        if (grant != '0)
        begin
            wr.wordAddr <= head[grantId].wordAddr;
            wr.data     <= head[grantId].data;
            wr.flush    <= (head[grantId].op == opStoreFlush);
        end
    end

endmodule

/* hdl/memRowPkg.sv */
package memRowPkg;

    // bank geometry, four rows of four words
    localparam int NumRows      = 4;
    localparam int RowWords     = 4;
    localparam int RowAddrWidth = 2;

    // one row as a single memory write
    localparam int RowDataWidth = RowWords * coreStorePkg::WordWidth;

    // row write to data memory
    // word 0 sits in the top bits of data, mask bit k belongs to word k
    typedef struct packed {
        logic [RowAddrWidth-1:0] rowAddr;
        logic [RowWords-1:0]     wordMask;
        logic [RowDataWidth-1:0] data;
    } memRow;

    // bank state as the flush stage sees it
    typedef struct packed {
        logic [NumRows-1:0]                   pending;
        logic [NumRows-1:0]                   partial;
        logic [NumRows-1:0][RowWords-1:0]     wordMask;
        logic [NumRows-1:0][RowDataWidth-1:0] rowData;
    } rowRequest;

endpackage

/* hdl/coreStorePkg.sv */
package coreStorePkg;

    // number of core store ports
    localparam int NumCores = 4;

    // one stored word
    localparam int WordWidth = 16;

    // word address into the sixteen-word bank, row in the upper bits
    localparam int WordAddrWidth = 4;

    // store opcodes as seen on the core side
    typedef enum logic {
        opStore      = 1'b0,
        opStoreFlush = 1'b1
    } coreOp;

    // one store as a core presents it
    typedef struct packed {
        coreOp                    op;
        logic [WordAddrWidth-1:0] wordAddr;
        logic [WordWidth-1:0]     data;
    } coreStore;

    // granted store handed from intake to the bank
    // flush forces the word's row out once the word lands
    typedef struct packed {
        logic [WordAddrWidth-1:0] wordAddr;
        logic [WordWidth-1:0]     data;
        logic                     flush;
    } bankWrite;

endpackage
